// File: design/ddr3_write.sv
`timescale 1ns/1ps

module ddr3_write (
    input  logic                      clk,
    input  logic                      rstn,
    input  ddr_axi_pkg::axi_aw_t      aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  ddr_axi_pkg::axi_w_t       w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output ddr_axi_pkg::axi_b_t       b,
    output logic                      b_valid,
    input  logic                      b_ready,
    output ddr_native_pkg::ddr_line_t line_out,
    output logic                      line_push,
    input  logic                      line_full,
    output ddr_native_pkg::ddr_cmd_t  cmd_out,
    output logic                      cmd_push,
    input  logic                      cmd_full,
    input  logic                      final_done
);
    localparam int AW = ddr_axi_pkg::AXI_ADDR_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_FLUSH,
        ST_RESP
    } state_t;

    state_t                          state;
    logic [ddr_axi_pkg::AXI_ID_W-1:0] id_q;
    logic [AW-1:0]                   burst_addr;
    logic [AW-1:0]                   end_addr;
    logic [AW-4:0]                   line_span;
    logic [2:0]                      lead_cnt;    // leading pad words left
    logic [2:0]                      trail_cnt;   // trailing pad words left
    logic [5:0]                      lines_left;  // up to 33 lines per write
    logic [4:0]                      burst_cnt;   // lines packed into current burst
    logic                            burst_done;
    logic                            cmd_wait;
    logic                            pad_now;
    ddr_axi_pkg::axi_w_t             pk_word;
    logic                            pk_valid;
    logic                            pk_ready;
    logic                            pk_take;

    assign end_addr  = aw.addr + {{(AW - 8){1'b0}}, aw.len};
    assign line_span = end_addr[AW-1:3] - aw.addr[AW-1:3];

    assign aw_ready = (state == ST_IDLE);

    // burst ends at 16 lines or at the last line of the write
    assign burst_done = (burst_cnt != '0) &&
                        ((burst_cnt == 5'(ddr_native_pkg::MAX_BURST)) ||
                         ({1'b0, burst_cnt} == lines_left));
    assign cmd_push   = burst_done && !cmd_full;
    assign cmd_wait   = burst_done && cmd_full;  // hold the packer until the command goes

    assign cmd_out.addr        = burst_addr;
    assign cmd_out.len         = 4'(burst_cnt - 5'd1);
    assign cmd_out.id          = id_q;
    assign cmd_out.final_burst = ({1'b0, burst_cnt} == lines_left);

    // pads first, AXI words in between, pads again after last
    assign pad_now  = ((state == ST_FILL) && (lead_cnt != '0)) ||
                      ((state == ST_FLUSH) && (trail_cnt != '0));
    assign pk_word  = pad_now ? '0 : w;
    assign pk_valid = !cmd_wait && (pad_now || ((state == ST_FILL) && w_valid));
    assign pk_take  = pk_valid && pk_ready;
    assign w_ready  = (state == ST_FILL) && (lead_cnt == '0) && pk_ready && !cmd_wait;

    assign b.id   = id_q;
    assign b.resp = ddr_axi_pkg::AXI_RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= ST_IDLE;
            lead_cnt   <= '0;
            trail_cnt  <= '0;
            lines_left <= '0;
            burst_cnt  <= '0;
            b_valid    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (aw_valid) begin
                        state      <= ST_FILL;
                        lead_cnt   <= aw.addr[2:0];
                        trail_cnt  <= 3'd7 - end_addr[2:0];
                        lines_left <= line_span[5:0] + 6'd1;
                    end
                end
                ST_FILL: begin
                    if (pad_now && pk_take)
                        lead_cnt <= lead_cnt - 3'd1;
                    if (w_valid && w_ready && w.last)
                        state <= ST_FLUSH;
                end
                ST_FLUSH: begin
                    if (pad_now && pk_take)
                        trail_cnt <= trail_cnt - 3'd1;
                    if (cmd_push && cmd_out.final_burst)
                        state <= ST_RESP;
                end
                ST_RESP: begin
                    if (b_valid && b_ready)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase

            if (cmd_push) begin
                burst_cnt  <= {4'd0, line_push};
                lines_left <= lines_left - {1'b0, burst_cnt};
            end else if (line_push) begin
                burst_cnt <= burst_cnt + 5'd1;
            end

            if (final_done)
                b_valid <= 1'b1;  // last line of final burst accepted by DDR
            else if (b_ready)
                b_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            id_q       <= aw.id;
            burst_addr <= {aw.addr[AW-1:3], 3'b000};  // line aligned
        end else if (cmd_push) begin
            burst_addr <= burst_addr + {{(AW - 8){1'b0}}, burst_cnt, 3'b000};
        end
    end

    word_packer u_packer (
        .clk        (clk),
        .rstn       (rstn),
        .word       (pk_word),
        .word_valid (pk_valid),
        .word_ready (pk_ready),
        .line_out   (line_out),
        .line_push  (line_push),
        .line_full  (line_full)
    );

endmodule

// File: design/ddr3_write_top.sv
`timescale 1ns/1ps

module ddr3_write_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  ddr_axi_pkg::axi_aw_t      aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  ddr_axi_pkg::axi_w_t       w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output ddr_axi_pkg::axi_b_t       b,
    output logic                      b_valid,
    input  logic                      b_ready,
    output ddr_native_pkg::ddr_cmd_t  ddr_cmd,
    output logic                      ddr_cmd_valid,
    input  logic                      ddr_cmd_ready,
    output ddr_native_pkg::ddr_line_t ddr_line,
    output logic                      ddr_line_valid,
    input  logic                      ddr_line_ready,
    output logic                      ddr_line_last
);
    ddr_native_pkg::ddr_line_t line_wr;
    ddr_native_pkg::ddr_line_t line_rd;
    ddr_native_pkg::ddr_cmd_t  cmd_wr;
    ddr_native_pkg::ddr_cmd_t  cmd_rd;
    logic                      line_push;
    logic                      line_pop;
    logic                      line_full;
    logic                      line_empty;
    logic                      cmd_push;
    logic                      cmd_pop;
    logic                      cmd_full;
    logic                      cmd_empty;
    logic                      final_done;

    ddr3_write u_write (
        .clk        (clk),
        .rstn       (rstn),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b          (b),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .line_out   (line_wr),
        .line_push  (line_push),
        .line_full  (line_full),
        .cmd_out    (cmd_wr),
        .cmd_push   (cmd_push),
        .cmd_full   (cmd_full),
        .final_done (final_done)
    );

    sync_fifo #(
        .payload_t (ddr_native_pkg::ddr_line_t),
        .DEPTH     (ddr_native_pkg::LINE_FIFO_DEPTH)
    ) u_line_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (line_push),
        .din   (line_wr),
        .pop   (line_pop),
        .dout  (line_rd),
        .full  (line_full),
        .empty (line_empty)
    );

    sync_fifo #(
        .payload_t (ddr_native_pkg::ddr_cmd_t),
        .DEPTH     (ddr_native_pkg::CMD_FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .push  (cmd_push),
        .din   (cmd_wr),
        .pop   (cmd_pop),
        .dout  (cmd_rd),
        .full  (cmd_full),
        .empty (cmd_empty)
    );

    ddr_burst_issuer u_issuer (
        .clk            (clk),
        .rstn           (rstn),
        .cmd_in         (cmd_rd),
        .cmd_empty      (cmd_empty),
        .cmd_pop        (cmd_pop),
        .line_in        (line_rd),
        .line_empty     (line_empty),
        .line_pop       (line_pop),
        .ddr_cmd        (ddr_cmd),
        .ddr_cmd_valid  (ddr_cmd_valid),
        .ddr_cmd_ready  (ddr_cmd_ready),
        .ddr_line       (ddr_line),
        .ddr_line_valid (ddr_line_valid),
        .ddr_line_ready (ddr_line_ready),
        .ddr_line_last  (ddr_line_last),
        .final_done     (final_done)
    );

endmodule

// File: design/ddr_axi_pkg.sv
package ddr_axi_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 28;  // word address
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // write address channel
    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;    // beats minus one
        logic [1:0]            burst;  // incrementing only
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_STRB_W-1:0] strb;
        logic                  last;
    } axi_w_t;

    // write response channel
    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

endpackage

// File: design/ddr_burst_issuer.sv
`timescale 1ns/1ps

module ddr_burst_issuer (
    input  logic                      clk,
    input  logic                      rstn,
    input  ddr_native_pkg::ddr_cmd_t  cmd_in,
    input  logic                      cmd_empty,
    output logic                      cmd_pop,
    input  ddr_native_pkg::ddr_line_t line_in,
    input  logic                      line_empty,
    output logic                      line_pop,
    output ddr_native_pkg::ddr_cmd_t  ddr_cmd,
    output logic                      ddr_cmd_valid,
    input  logic                      ddr_cmd_ready,
    output ddr_native_pkg::ddr_line_t ddr_line,
    output logic                      ddr_line_valid,
    input  logic                      ddr_line_ready,
    output logic                      ddr_line_last,
    output logic                      final_done
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_t;

    state_t                                state;
    logic [ddr_native_pkg::DDR_LEN_W-1:0] beat;
    logic                                  line_xfer;

    assign cmd_pop        = (state == ST_IDLE) && !cmd_empty;
    assign ddr_cmd_valid  = (state == ST_ADDR);
    assign ddr_line       = line_in;
    assign ddr_line_valid = (state == ST_DATA) && !line_empty;  // lines are queued before the cmd
    assign ddr_line_last  = (state == ST_DATA) && (beat == ddr_cmd.len);
    assign line_xfer      = ddr_line_valid && ddr_line_ready;
    assign line_pop       = line_xfer;
    assign final_done     = line_xfer && ddr_line_last && ddr_cmd.final_burst;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!cmd_empty)
                        state <= ST_ADDR;
                end
                ST_ADDR: begin
                    if (ddr_cmd_ready) begin
                        state <= ST_DATA;
                        beat  <= '0;
                    end
                end
                ST_DATA: begin
                    if (line_xfer) begin
                        if (ddr_line_last)
                            state <= ST_IDLE;
                        else
                            beat <= beat + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // head command held for the whole burst
    always_ff @(posedge clk) begin
        if (cmd_pop)
            ddr_cmd <= cmd_in;
    end

endmodule

// File: design/ddr_native_pkg.sv
package ddr_native_pkg;

    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = 256;
    localparam int LINE_STRB_W    = LINE_W / 8;
    localparam int MAX_BURST      = 16;   // lines per native burst
    localparam int DDR_ADDR_W     = 28;   // word address, same space as AXI
    localparam int DDR_ID_W       = 4;
    localparam int DDR_LEN_W      = 4;    // lines minus one

    localparam int LINE_FIFO_DEPTH = 32;  // two full bursts
    localparam int CMD_FIFO_DEPTH  = 4;

    // one DDR line
    typedef struct packed {
        logic [LINE_W-1:0]      data;
        logic [LINE_STRB_W-1:0] strb;
    } ddr_line_t;

    // one native burst command
    typedef struct packed {
        logic [DDR_ADDR_W-1:0] addr;         // low 3 bits always zero
        logic [DDR_LEN_W-1:0]  len;
        logic [DDR_ID_W-1:0]   id;
        logic                  final_burst;  // last burst of the AXI write
    } ddr_cmd_t;

endpackage

// File: design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output payload_t dout,
    output logic     full,
    output logic     empty
);
    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // push on full is dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    assign dout  = mem[rd_ptr];  // head entry
    assign full  = (count == (PTR_W + 1)'(DEPTH));
    assign empty = (count == '0);

endmodule

// File: design/word_packer.sv
`timescale 1ns/1ps

module word_packer (
    input  logic                      clk,
    input  logic                      rstn,
    input  ddr_axi_pkg::axi_w_t       word,
    input  logic                      word_valid,
    output logic                      word_ready,
    output ddr_native_pkg::ddr_line_t line_out,
    output logic                      line_push,
    input  logic                      line_full
);
    localparam int SLOT_W = $clog2(ddr_native_pkg::WORDS_PER_LINE);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(ddr_native_pkg::WORDS_PER_LINE - 1);

    logic [SLOT_W-1:0] slot;  // lane for the next word
    logic              take;

    assign word_ready = !line_full;
    assign take       = word_valid && word_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            slot      <= '0;
            line_push <= 1'b0;
        end else begin
            line_push <= take && (slot == LAST_SLOT);  // line complete after 8th word
            if (take)
                slot <= slot + 1'b1;  // wraps to lane 0
        end
    end

    // word 0 sits in the lowest lane
    always_ff @(posedge clk) begin
        if (take) begin
            line_out.data[slot*ddr_axi_pkg::AXI_DATA_W +: ddr_axi_pkg::AXI_DATA_W] <= word.data;
            line_out.strb[slot*ddr_axi_pkg::AXI_STRB_W +: ddr_axi_pkg::AXI_STRB_W] <= word.strb;
        end
    end

endmodule

// File: filelist.f
design/ddr_axi_pkg.sv
design/ddr_native_pkg.sv
design/sync_fifo.sv
design/word_packer.sv
design/ddr3_write.sv
design/ddr_burst_issuer.sv
design/ddr3_write_top.sv
testbench/tb_ddr3_write.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -sv -f filelist.f --top-module tb_ddr3_write -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation done"

// File: testbench/tb_ddr3_write.sv
`timescale 1ns/1ps

module tb_ddr3_write;

    localparam int N_TXN = 5;
    localparam int REC_W = 8;  // words per record in the pattern file
    localparam logic [31:0] LFSR_SEED = 32'hd610_6ea8;

    logic                      clk;
    logic                      rstn;
    ddr_axi_pkg::axi_aw_t      aw;
    logic                      aw_valid;
    logic                      aw_ready;
    ddr_axi_pkg::axi_w_t       w;
    logic                      w_valid;
    logic                      w_ready;
    ddr_axi_pkg::axi_b_t       b;
    logic                      b_valid;
    logic                      b_ready;
    ddr_native_pkg::ddr_cmd_t  ddr_cmd;
    logic                      ddr_cmd_valid;
    logic                      ddr_cmd_ready;
    ddr_native_pkg::ddr_line_t ddr_line;
    logic                      ddr_line_valid;
    logic                      ddr_line_ready;
    logic                      ddr_line_last;

    logic [39:0]               patterns [N_TXN*REC_W];
    logic [31:0]               lfsr;
    ddr_native_pkg::ddr_line_t exp_lines [$];
    ddr_native_pkg::ddr_cmd_t  exp_cmds [$];
    logic [3:0]                exp_ids [$];
    ddr_native_pkg::ddr_line_t cur_line;    // reference line being packed
    int                        slot;
    ddr_native_pkg::ddr_cmd_t  cur_cmd;     // expected burst in progress on the DDR side
    logic                      burst_active;
    logic                      final_seen;
    logic                      in_txn;
    logic                      aw_fire;
    logic                      w_fire;
    logic                      b_fire;
    int                        beat_idx;
    int                        cmd_count;
    int                        total_cmds;
    int                        b_count;
    int                        cycles;
    int                        cycle_limit;

    ddr3_write_top ddr3_write_top_inst (
        .clk            (clk),
        .rstn           (rstn),
        .aw             (aw),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w              (w),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .ddr_cmd        (ddr_cmd),
        .ddr_cmd_valid  (ddr_cmd_valid),
        .ddr_cmd_ready  (ddr_cmd_ready),
        .ddr_line       (ddr_line),
        .ddr_line_valid (ddr_line_valid),
        .ddr_line_ready (ddr_line_ready),
        .ddr_line_last  (ddr_line_last)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic die(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [287:0] exp,
                               input logic [287:0] act);
        assert (exp === act) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            die("value mismatch");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic bit_out);
        lfsr    = lfsr_next(lfsr);
        bit_out = lfsr[0];
    endtask

    task automatic take_word(output logic [31:0] word_out);
        logic bit_v;
        word_out = '0;
        for (int i = 0; i < 32; i++) begin
            take_bit(bit_v);
            word_out = {word_out[30:0], bit_v};
        end
    endtask

    // reference packer with lane 0 in the low bits
    task automatic add_lane(input logic [31:0] data, input logic [3:0] strb);
        cur_line.data[slot*32 +: 32] = data;
        cur_line.strb[slot*4 +: 4]   = strb;
        slot++;
        if (slot == ddr_native_pkg::WORDS_PER_LINE) begin
            exp_lines.push_back(cur_line);
            slot = 0;
        end
    endtask

    task automatic next_cycle();
        logic r;
        @(negedge clk);
        take_bit(r);
        ddr_cmd_ready = r;
        take_bit(r);
        ddr_line_ready = r;
        take_bit(r);
        b_ready = r;
    endtask

    task automatic check_idle_outputs(input string when);
        assert (aw_ready === 1'b1 && w_ready === 1'b0 && b_valid === 1'b0 &&
                ddr_cmd_valid === 1'b0 && ddr_line_valid === 1'b0)
        else die($sformatf("outputs not in reset state %s", when));
    endtask

    task automatic run_txn(input int t);
        int          base;
        logic [3:0]  a_id;
        logic [27:0] a_addr;
        logic [7:0]  a_len;
        logic [31:0] seed;
        logic [27:0] end_addr;
        logic [31:0] rnd;
        logic        send;
        int          beats;
        int          k;
        ddr_native_pkg::ddr_cmd_t c;
        base     = t * REC_W;
        a_id     = patterns[base][3:0];
        a_addr   = patterns[base+1][27:0];
        a_len    = patterns[base+2][7:0];
        seed     = patterns[base+3][31:0];
        end_addr = a_addr + 28'(a_len);
        beats    = int'(a_len) + 1;
        for (int i = 0; i < int'(patterns[base+4]); i++) begin
            c.addr        = patterns[base+5+i][35:8];
            c.len         = patterns[base+5+i][7:4];
            c.id          = a_id;
            c.final_burst = patterns[base+5+i][0];
            exp_cmds.push_back(c);
        end
        exp_ids.push_back(a_id);
        for (int i = 0; i < int'(a_addr[2:0]); i++)
            add_lane(32'h0, 4'h0);  // leading pads
        aw.id    = a_id;
        aw.addr  = a_addr;
        aw.len   = a_len;
        aw.burst = 2'b01;
        aw_valid = 1'b1;
        do next_cycle(); while (!aw_fire);
        aw_valid = 1'b0;
        k = 0;
        while (k < beats) begin
            if (!w_valid) begin
                take_bit(send);  // random gaps on w_valid
                if (send) begin
                    take_word(rnd);
                    w.data  = rnd ^ seed;
                    w.strb  = 4'hf;
                    w.last  = (k == beats - 1);
                    w_valid = 1'b1;
                    add_lane(w.data, w.strb);
                end
            end
            next_cycle();
            if (w_fire) begin
                k++;
                w_valid = 1'b0;
            end
        end
        for (int i = 0; i < 7 - int'(end_addr[2:0]); i++)
            add_lane(32'h0, 4'h0);  // trailing pads
        while (b_count <= t)
            next_cycle();
    endtask

    // monitor and DDR sink checker
    always @(posedge clk) begin
        aw_fire = aw_valid && aw_ready;
        w_fire  = w_valid && w_ready;
        b_fire  = b_valid && b_ready;
        cycles++;
        if (cycles > cycle_limit)
            die("timeout, the DUT stopped making progress");
        if (rstn) begin
            assert (!(in_txn && aw_ready)) else die("aw_ready high during a transaction");
            assert (!ddr_line_valid || burst_active) else die("line offered before its command");
            if (ddr_line_valid && ddr_line_ready) begin
                assert (exp_lines.size() > 0) else die("DDR line with none expected");
                check_value("ddr_line", 288'(exp_lines.pop_front()), 288'(ddr_line));
                check_value("ddr_line_last", 288'(beat_idx == int'(cur_cmd.len)),
                            288'(ddr_line_last));
                if (beat_idx == int'(cur_cmd.len)) begin
                    burst_active = 1'b0;
                    if (cur_cmd.final_burst)
                        final_seen = 1'b1;
                end
                beat_idx++;
            end
            if (ddr_cmd_valid && ddr_cmd_ready) begin
                assert (exp_cmds.size() > 0) else die("DDR command with none expected");
                cur_cmd = exp_cmds.pop_front();
                check_value("ddr_cmd", 288'(cur_cmd), 288'(ddr_cmd));
                burst_active = 1'b1;
                beat_idx     = 0;
                cmd_count++;
            end
            if (b_fire) begin
                assert (in_txn) else die("write response without a transaction");
                assert (final_seen) else die("write response before the final line");
                check_value("b.id", 288'(exp_ids.pop_front()), 288'(b.id));
                check_value("b.resp", 288'(ddr_axi_pkg::AXI_RESP_OKAY), 288'(b.resp));
                final_seen = 1'b0;
                b_count++;
            end
            if (aw_fire)
                in_txn = 1'b1;
            if (b_fire)
                in_txn = 1'b0;
        end
    end

    initial begin
        int total_beats;
        lfsr         = LFSR_SEED;
        rstn         = 1'b0;
        aw           = '0;
        aw_valid     = 1'b0;
        w            = '0;
        w_valid      = 1'b0;
        b_ready      = 1'b0;
        ddr_cmd_ready  = 1'b0;
        ddr_line_ready = 1'b0;
        cur_line     = '0;
        slot         = 0;
        burst_active = 1'b0;
        final_seen   = 1'b0;
        in_txn       = 1'b0;
        cmd_count    = 0;
        b_count      = 0;
        cycles       = 0;
        total_cmds   = 0;
        total_beats  = 0;
        $readmemh("testbench/write_patterns.txt", patterns);
        for (int t = 0; t < N_TXN; t++) begin
            total_beats += int'(patterns[t*REC_W+2][7:0]) + 1;
            total_cmds  += int'(patterns[t*REC_W+4]);
        end
        cycle_limit = 40 * total_beats + 200;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (i > 0)
                check_idle_outputs("during reset");
        end
        rstn = 1'b1;
        @(negedge clk);
        check_idle_outputs("after reset");
        for (int t = 0; t < N_TXN; t++)
            run_txn(t);
        assert (exp_lines.size() == 0 && exp_cmds.size() == 0 && slot == 0)
        else die("expected lines or commands left over");
        check_value("command count", 288'(total_cmds), 288'(cmd_count));
        $display("** PASS **");
        $finish;
    end

endmodule

// File: testbench/write_patterns.txt
// id addr len seed ncmd cmd0 cmd1 cmd2, one word per line
// cmd word = {line address, len, final}, unused cmd slots are zero
0000000001
0000000100
0000000007
00a5a5a5a5
0000000001
0000010001
0000000000
0000000000
0000000002
0000000203
0000000002
0012345678
0000000001
0000020001
0000000000
0000000000
0000000003
0000001000
000000007f
00deadbeef
0000000001
00001000f1
0000000000
0000000000
0000000004
0000002005
0000000082
000f0f0f0f
0000000002
00002000f0
0000208001
0000000000
0000000005
0000003001
00000000ff
0000c0ffee
0000000003
00003000f0
00003080f0
0000310001
